// ==== design/afi_seq_pkg.sv ====
/*
 * Shared definitions for the sequencer to AFI control bridge.
 * Holds field widths, the Wishbone register map, the control word with its
 * raw and field views, and the controller status word.
 */
package afi_seq_pkg;

   //////////////////////////////////////////////////
   // Field and bus widths
   //////////////////////////////////////////////////

   localparam int AFI_RLAT_W     = 6;
   localparam int AFI_WLAT_W     = 6;
   localparam int AFI_SEQ_BUSY_W = 4;
   localparam int WB_DATA_W      = 32;
   localparam int WB_ADDR_W      = 2;

   // Depth of the calibration status synchronizer
   localparam int SYNC_LENGTH = 3;

   // Word addresses of the register map
   localparam logic [WB_ADDR_W-1:0] CSR_CTRL   = 2'd0;
   localparam logic [WB_ADDR_W-1:0] CSR_STATUS = 2'd1;
   localparam logic [WB_ADDR_W-1:0] CSR_EVENT  = 2'd2;

   //////////////////////////////////////////////////
   // Control and status words
   //////////////////////////////////////////////////

   // Listed from the top bit down, so rlat sits at bit 0
   typedef struct packed {
      logic [9:0]                reserved;
      logic                      dcc_stable;
      logic                      oct_s2pload_ena;
      logic                      oct_cal_req;
      logic                      cal_fail;
      logic                      cal_success;
      logic                      cal_in_progress;
      logic [AFI_SEQ_BUSY_W-1:0] seq_busy;
      logic [AFI_WLAT_W-1:0]     wlat;
      logic [AFI_RLAT_W-1:0]     rlat;
   } seq_ctrl_t;

   // Firmware writes the raw word, the bridge reads the fields
   typedef union packed {
      logic [WB_DATA_W-1:0] raw;
      seq_ctrl_t            f;
   } seq_ctrl_u;

   // Controller and OCT status, cal_req at bit 0
   typedef struct packed {
      logic oct_s2pload_rdy;
      logic oct_recal_req;
      logic oct_cal_rdy;
      logic long_idle;
      logic refresh_done;
      logic cal_req;
   } ctl_status_t;

endpackage

// ==== design/afi_seq_ctl_if.sv ====
/*
 * Link between the CSR stage and the PHY-side stage.
 * The CSR side drives the decoded control word, the PHY side returns the
 * delayed controller status. Both are plain registered values.
 */
`timescale 1ns/1ns

interface afi_seq_ctl_if
   import afi_seq_pkg::*;
();

   // Control fields toward the AFI outputs
   seq_ctrl_t   ctrl;

   // Controller and OCT inputs after the AFI register delay
   ctl_status_t status;

   modport csr (
      output ctrl,
      input  status
   );

   modport phy (
      input  ctrl,
      output status
   );

endinterface

// ==== design/afi_delay_regs.sv ====
/*
 * Register chain of STAGES flops on a WIDTH-bit bus, cleared by reset.
 * With STAGES at zero the bus passes straight through. Used for the AFI
 * register stages and for the calibration status synchronizer.
 */
`timescale 1ns/1ns

module afi_delay_regs #(
   parameter int STAGES = 1,
   parameter int WIDTH  = 1
) (
   input  logic             afi_clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] data_in,
   output logic [WIDTH-1:0] data_out
);

   generate
      if (STAGES == 0) begin : gen_wire
         assign data_out = data_in;
      end else begin : gen_chain
         logic [WIDTH-1:0] stage_q [STAGES];

         always_ff @(posedge afi_clk) begin
            if (rst) begin
               for (int i = 0; i < STAGES; i++) begin
                  stage_q[i] <= '0;
               end
            end else begin
               stage_q[0] <= data_in;
               for (int i = 1; i < STAGES; i++) begin
                  stage_q[i] <= stage_q[i-1];
               end
            end
         end

         // Last flop of the chain
         assign data_out = stage_q[STAGES-1];
      end
   endgenerate

endmodule

// ==== design/afi_seq_csr.sv ====
/*
 * Wishbone classic slave for the calibration sequencer.
 * Holds CTRL, a STATUS snapshot of the controller inputs and the sticky
 * EVENT bits. Each transfer is acknowledged for one cycle, one cycle after
 * the strobe is seen.
 */
`timescale 1ns/1ns

module afi_seq_csr
   import afi_seq_pkg::*;
(
   input  logic                 afi_clk,
   input  logic                 rst,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [WB_ADDR_W-1:0] wb_adr,
   input  logic [WB_DATA_W-1:0] wb_wdata,
   output logic [WB_DATA_W-1:0] wb_rdata,
   output logic                 wb_ack,
   afi_seq_ctl_if.csr           ctl
);

   // EVENT bit positions
   localparam int EVT_W         = 2;
   localparam int EVT_CAL_REQ   = 0;
   localparam int EVT_OCT_RECAL = 1;

   localparam int STATUS_W = $bits(ctl_status_t);

   seq_ctrl_u        ctrl_q;
   ctl_status_t      status_q;
   logic [EVT_W-1:0] event_q;

   logic             xfer;
   logic             wr_en;
   logic [EVT_W-1:0] req_now;
   logic [EVT_W-1:0] req_prev;
   logic [EVT_W-1:0] evt_set;
   logic [EVT_W-1:0] evt_clr;

   //////////////////////////////////////////////////
   // Bus handshake
   //////////////////////////////////////////////////

   // A new transfer is one not yet acknowledged
   assign xfer  = wb_cyc && wb_stb && !wb_ack;
   assign wr_en = xfer && wb_we;

   always_ff @(posedge afi_clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= xfer;
      end
   end

   //////////////////////////////////////////////////
   // Control register
   //////////////////////////////////////////////////

   // The whole word is stored, reserved bits included
   always_ff @(posedge afi_clk) begin
      if (rst) begin
         ctrl_q.raw <= '0;
      end else if (wr_en && (wb_adr == CSR_CTRL)) begin
         ctrl_q.raw <= wb_wdata;
      end
   end

   assign ctl.ctrl = ctrl_q.f;

   //////////////////////////////////////////////////
   // Status snapshot and sticky events
   //////////////////////////////////////////////////

   always_ff @(posedge afi_clk) begin
      if (rst) begin
         status_q <= '0;
         req_prev <= '0;
      end else begin
         status_q <= ctl.status;
         req_prev <= req_now;
      end
   end

   assign req_now[EVT_CAL_REQ]   = status_q.cal_req;
   assign req_now[EVT_OCT_RECAL] = status_q.oct_recal_req;

   // Rising edges of the two request lines
   assign evt_set = req_now & ~req_prev;

   assign evt_clr = (wr_en && (wb_adr == CSR_EVENT)) ? wb_wdata[EVT_W-1:0] : '0;

   // A new event in the same cycle as its clear is kept
   always_ff @(posedge afi_clk) begin
      if (rst) begin
         event_q <= '0;
      end else begin
         event_q <= (event_q & ~evt_clr) | evt_set;
      end
   end

   //////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////

   // Captured on the edge that raises ack, so it is valid with ack
   always_ff @(posedge afi_clk) begin
      if (xfer) begin
         case (wb_adr)
            CSR_CTRL: begin
               wb_rdata <= ctrl_q.raw;
            end
            CSR_STATUS: begin
               wb_rdata <= {{(WB_DATA_W-STATUS_W){1'b0}}, status_q};
            end
            CSR_EVENT: begin
               wb_rdata <= {{(WB_DATA_W-EVT_W){1'b0}}, event_q};
            end
            default: begin
               wb_rdata <= '0;
            end
         endcase
      end
   end

endmodule

// ==== design/afi_seq_phy_if.sv ====
/*
 * PHY-side stage of the bridge.
 * Drives the AFI latency, busy and calibration outputs and the OCT and DCC
 * controls from the control word, and returns the controller inputs to the
 * CSR stage through the same AFI register delay.
 */
`timescale 1ns/1ns

module afi_seq_phy_if
   import afi_seq_pkg::*;
#(
   parameter int REGISTER_AFI           = 1,
   parameter int PHY_USERMODE_OCT       = 0,
   parameter int PHY_PERIODIC_OCT_RECAL = 0,
   parameter int PHY_HAS_DCC            = 0
) (
   input  logic                      afi_clk,
   input  logic                      rst,
   afi_seq_ctl_if.phy                ctl,
   output logic [AFI_RLAT_W-1:0]     afi_rlat,
   output logic [AFI_WLAT_W-1:0]     afi_wlat,
   output logic [AFI_SEQ_BUSY_W-1:0] afi_seq_busy,
   output logic                      afi_cal_success,
   output logic                      afi_cal_fail,
   output logic                      afi_cal_in_progress,
   input  logic                      afi_cal_req,
   input  logic                      afi_ctl_refresh_done,
   input  logic                      afi_ctl_long_idle,
   output logic                      oct_cal_req,
   input  logic                      oct_cal_rdy,
   input  logic                      oct_recal_req,
   output logic                      oct_s2pload_ena,
   input  logic                      oct_s2pload_rdy,
   output logic                      dcc_stable
);

   localparam int LAT_W = AFI_SEQ_BUSY_W + AFI_WLAT_W + AFI_RLAT_W;

   logic [LAT_W-1:0]      lat_q;
   logic [AFI_RLAT_W-1:0] rlat_q;
   logic [2:0]            cal_q;
   ctl_status_t           ctl_in;
   ctl_status_t           ctl_q;

   //////////////////////////////////////////////////
   // Latency and busy
   //////////////////////////////////////////////////

   afi_delay_regs #(
      .STAGES (REGISTER_AFI),
      .WIDTH  (LAT_W)
   ) lat_regs (
      .afi_clk  (afi_clk),
      .rst      (rst),
      .data_in  ({ctl.ctrl.seq_busy, ctl.ctrl.wlat, ctl.ctrl.rlat}),
      .data_out (lat_q)
   );

   assign {afi_seq_busy, afi_wlat, rlat_q} = lat_q;

   // The AFI register stage adds two cycles to the read return path
   assign afi_rlat = (REGISTER_AFI != 0) ? (rlat_q + AFI_RLAT_W'(2)) : rlat_q;

   //////////////////////////////////////////////////
   // Calibration status synchronizer
   //////////////////////////////////////////////////

   afi_delay_regs #(
      .STAGES (SYNC_LENGTH),
      .WIDTH  (3)
   ) cal_sync (
      .afi_clk  (afi_clk),
      .rst      (rst),
      .data_in  ({ctl.ctrl.cal_fail, ctl.ctrl.cal_success, ctl.ctrl.cal_in_progress}),
      .data_out (cal_q)
   );

   assign {afi_cal_fail, afi_cal_success, afi_cal_in_progress} = cal_q;

   //////////////////////////////////////////////////
   // OCT and DCC controls
   //////////////////////////////////////////////////

   generate
      if (PHY_USERMODE_OCT != 0) begin : gen_oct_cal_req
         afi_delay_regs #(
            .STAGES (REGISTER_AFI),
            .WIDTH  (1)
         ) oct_cal_req_regs (
            .afi_clk  (afi_clk),
            .rst      (rst),
            .data_in  (ctl.ctrl.oct_cal_req),
            .data_out (oct_cal_req)
         );
      end else begin : gen_no_oct_cal_req
         assign oct_cal_req = 1'b0;
      end

      // Without periodic recalibration the load stays enabled
      if (PHY_PERIODIC_OCT_RECAL != 0) begin : gen_s2pload_ena
         afi_delay_regs #(
            .STAGES (REGISTER_AFI),
            .WIDTH  (1)
         ) oct_s2pload_ena_regs (
            .afi_clk  (afi_clk),
            .rst      (rst),
            .data_in  (ctl.ctrl.oct_s2pload_ena),
            .data_out (oct_s2pload_ena)
         );
      end else begin : gen_no_s2pload_ena
         assign oct_s2pload_ena = 1'b1;
      end

      if (PHY_HAS_DCC != 0) begin : gen_dcc
         assign dcc_stable = ctl.ctrl.dcc_stable;
      end else begin : gen_no_dcc
         assign dcc_stable = 1'b1;
      end
   endgenerate

   //////////////////////////////////////////////////
   // Controller inputs back to the CSR stage
   //////////////////////////////////////////////////

   // Inputs of a disabled feature read as zero
   assign ctl_in.cal_req         = afi_cal_req;
   assign ctl_in.refresh_done    = afi_ctl_refresh_done;
   assign ctl_in.long_idle       = afi_ctl_long_idle;
   assign ctl_in.oct_cal_rdy     = (PHY_USERMODE_OCT != 0) && oct_cal_rdy;
   assign ctl_in.oct_recal_req   = (PHY_PERIODIC_OCT_RECAL != 0) && oct_recal_req;
   assign ctl_in.oct_s2pload_rdy = (PHY_PERIODIC_OCT_RECAL != 0) && oct_s2pload_rdy;

   afi_delay_regs #(
      .STAGES (REGISTER_AFI),
      .WIDTH  ($bits(ctl_status_t))
   ) ctl_in_regs (
      .afi_clk  (afi_clk),
      .rst      (rst),
      .data_in  (ctl_in),
      .data_out (ctl_q)
   );

   assign ctl.status = ctl_q;

endmodule

// ==== design/afi_seq_top.sv ====
/*
 * Top level of the sequencer to AFI control bridge.
 * Firmware programs the control word over Wishbone classic, the PHY-side
 * stage turns it into AFI, OCT and DCC signals. Set the feature parameters
 * here, they are passed down to the PHY-side stage.
 */
`timescale 1ns/1ns

module afi_seq_top
   import afi_seq_pkg::*;
#(
   parameter int REGISTER_AFI           = 1,
   parameter int PHY_USERMODE_OCT       = 0,
   parameter int PHY_PERIODIC_OCT_RECAL = 0,
   parameter int PHY_HAS_DCC            = 0
) (
   input  logic                      afi_clk,
   input  logic                      rst,
   // Wishbone classic slave
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [WB_ADDR_W-1:0]      wb_adr,
   input  logic [WB_DATA_W-1:0]      wb_wdata,
   output logic [WB_DATA_W-1:0]      wb_rdata,
   output logic                      wb_ack,
   // AFI side
   output logic [AFI_RLAT_W-1:0]     afi_rlat,
   output logic [AFI_WLAT_W-1:0]     afi_wlat,
   output logic [AFI_SEQ_BUSY_W-1:0] afi_seq_busy,
   output logic                      afi_cal_success,
   output logic                      afi_cal_fail,
   output logic                      afi_cal_in_progress,
   input  logic                      afi_cal_req,
   input  logic                      afi_ctl_refresh_done,
   input  logic                      afi_ctl_long_idle,
   // OCT and DCC
   output logic                      oct_cal_req,
   input  logic                      oct_cal_rdy,
   input  logic                      oct_recal_req,
   output logic                      oct_s2pload_ena,
   input  logic                      oct_s2pload_rdy,
   output logic                      dcc_stable
);

   afi_seq_ctl_if ctl_bus ();

   // Register stage
   afi_seq_csr csr_i (
      .afi_clk  (afi_clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack),
      .ctl      (ctl_bus)
   );

   // AFI interface stage
   afi_seq_phy_if #(
      .REGISTER_AFI           (REGISTER_AFI),
      .PHY_USERMODE_OCT       (PHY_USERMODE_OCT),
      .PHY_PERIODIC_OCT_RECAL (PHY_PERIODIC_OCT_RECAL),
      .PHY_HAS_DCC            (PHY_HAS_DCC)
   ) phy_i (
      .afi_clk              (afi_clk),
      .rst                  (rst),
      .ctl                  (ctl_bus),
      .afi_rlat             (afi_rlat),
      .afi_wlat             (afi_wlat),
      .afi_seq_busy         (afi_seq_busy),
      .afi_cal_success      (afi_cal_success),
      .afi_cal_fail         (afi_cal_fail),
      .afi_cal_in_progress  (afi_cal_in_progress),
      .afi_cal_req          (afi_cal_req),
      .afi_ctl_refresh_done (afi_ctl_refresh_done),
      .afi_ctl_long_idle    (afi_ctl_long_idle),
      .oct_cal_req          (oct_cal_req),
      .oct_cal_rdy          (oct_cal_rdy),
      .oct_recal_req        (oct_recal_req),
      .oct_s2pload_ena      (oct_s2pload_ena),
      .oct_s2pload_rdy      (oct_s2pload_rdy),
      .dcc_stable           (dcc_stable)
   );

endmodule

// ==== sim/tb_afi_seq_checks.svh ====
/*
 * Compare tasks, error counters and the random word source for the
 * bridge testbench. Included in the body of the testbench module, after
 * the package import.
 */
`ifndef TB_AFI_SEQ_CHECKS_SVH
`define TB_AFI_SEQ_CHECKS_SVH

   int error_count   = 0;
   int check_count   = 0;
   int timeout_count = 0;

   // Feedback mask of x^32 + x^22 + x^2 + x + 1 for a right-shifting LFSR
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   logic [31:0] lfsr_state = 32'h7338f836;

   //////////////////////////////////////////////////
   // Random words
   //////////////////////////////////////////////////

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   // One LFSR step for every bit taken
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < count; i++) begin
         w[i] = lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
      end
      return w;
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic check_ctrl(input string name, input seq_ctrl_t got, input seq_ctrl_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
      end
   endtask

   task automatic check_status(input string name, input ctl_status_t got,
                               input ctl_status_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("ERROR t=%0t %s got=%b expected=%b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("ERROR t=%0t %s got=%b expected=%b", $time, name, got, exp);
      end
   endtask

   // Bus words and zero-extended output fields
   task automatic check_word(input string name, input logic [WB_DATA_W-1:0] got,
                             input logic [WB_DATA_W-1:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
      end
   endtask

   task automatic note_timeout(input string what);
      timeout_count++;
      $display("Timed out at t=%0t while waiting for %s", $time, what);
   endtask

`endif

// ==== sim/tb_afi_seq.sv ====
/*
 * Directed testbench for the sequencer to AFI control bridge.
 * Runs the DUT with two AFI register stages and all OCT and DCC features on,
 * drives Wishbone transfers and the controller inputs, and checks the AFI
 * outputs, the register map and the bus handshake.
 */
`timescale 1ns/1ns

module tb_afi_seq
   import afi_seq_pkg::*;
;

   localparam int REG_AFI      = 2;
   localparam int ACK_TIMEOUT  = 16;
   localparam int EVT_CAL_REQ  = 0;
   localparam int EVT_OCT_RCAL = 1;

   logic                      afi_clk;
   logic                      rst;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [WB_ADDR_W-1:0]      wb_adr;
   logic [WB_DATA_W-1:0]      wb_wdata;
   logic [WB_DATA_W-1:0]      wb_rdata;
   logic                      wb_ack;
   logic [AFI_RLAT_W-1:0]     afi_rlat;
   logic [AFI_WLAT_W-1:0]     afi_wlat;
   logic [AFI_SEQ_BUSY_W-1:0] afi_seq_busy;
   logic                      afi_cal_success;
   logic                      afi_cal_fail;
   logic                      afi_cal_in_progress;
   logic                      afi_cal_req;
   logic                      afi_ctl_refresh_done;
   logic                      afi_ctl_long_idle;
   logic                      oct_cal_req;
   logic                      oct_cal_rdy;
   logic                      oct_recal_req;
   logic                      oct_s2pload_ena;
   logic                      oct_s2pload_rdy;
   logic                      dcc_stable;

   int xfer_count = 0;
   int ack_cycles = 0;

   `include "tb_afi_seq_checks.svh"

   afi_seq_top #(
      .REGISTER_AFI           (REG_AFI),
      .PHY_USERMODE_OCT       (1),
      .PHY_PERIODIC_OCT_RECAL (1),
      .PHY_HAS_DCC            (1)
   ) dut_i (
      .afi_clk              (afi_clk),
      .rst                  (rst),
      .wb_cyc               (wb_cyc),
      .wb_stb               (wb_stb),
      .wb_we                (wb_we),
      .wb_adr               (wb_adr),
      .wb_wdata             (wb_wdata),
      .wb_rdata             (wb_rdata),
      .wb_ack               (wb_ack),
      .afi_rlat             (afi_rlat),
      .afi_wlat             (afi_wlat),
      .afi_seq_busy         (afi_seq_busy),
      .afi_cal_success      (afi_cal_success),
      .afi_cal_fail         (afi_cal_fail),
      .afi_cal_in_progress  (afi_cal_in_progress),
      .afi_cal_req          (afi_cal_req),
      .afi_ctl_refresh_done (afi_ctl_refresh_done),
      .afi_ctl_long_idle    (afi_ctl_long_idle),
      .oct_cal_req          (oct_cal_req),
      .oct_cal_rdy          (oct_cal_rdy),
      .oct_recal_req        (oct_recal_req),
      .oct_s2pload_ena      (oct_s2pload_ena),
      .oct_s2pload_rdy      (oct_s2pload_rdy),
      .dcc_stable           (dcc_stable)
   );

   initial begin
      afi_clk = 1'b0;
      forever #5 afi_clk = ~afi_clk;
   end

   // Counts every high ack cycle, which each transfer raises exactly once
   always @(negedge afi_clk) begin
      if (!rst && wb_ack) begin
         ack_cycles <= ack_cycles + 1;
      end
   end

   //////////////////////////////////////////////////
   // Wishbone master
   //////////////////////////////////////////////////

   // Returns on the falling edge where ack is high
   task automatic wb_issue(input logic we, input logic [WB_ADDR_W-1:0] adr,
                           input logic [WB_DATA_W-1:0] wdata,
                           output logic [WB_DATA_W-1:0] rdata);
      int   waited;
      logic got_ack;
      @(posedge afi_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_wdata <= wdata;
      xfer_count++;
      @(negedge afi_clk);
      check_bit("wb_ack", wb_ack, 1'b0);
      waited  = 0;
      got_ack = 1'b0;
      while (!got_ack && waited < ACK_TIMEOUT) begin
         @(negedge afi_clk);
         waited++;
         got_ack = wb_ack;
      end
      if (!got_ack) begin
         note_timeout("wb_ack");
      end else if (waited != 1) begin
         error_count++;
         $display("Ack came %0d cycles late at t=%0t", waited - 1, $time);
      end
      rdata = wb_rdata;
   endtask

   // Ack must fall again right after the strobe is dropped
   task automatic wb_release();
      @(posedge afi_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge afi_clk);
      check_bit("wb_ack", wb_ack, 1'b0);
   endtask

   task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
      logic [WB_DATA_W-1:0] unused;
      wb_issue(1'b1, adr, data, unused);
      wb_release();
   endtask

   task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] data);
      wb_issue(1'b0, adr, '0, data);
      wb_release();
   endtask

   //////////////////////////////////////////////////
   // Stimulus and expected outputs
   //////////////////////////////////////////////////

   task automatic apply_ctl_inputs(input ctl_status_t s);
      @(posedge afi_clk);
      afi_cal_req          <= s.cal_req;
      afi_ctl_refresh_done <= s.refresh_done;
      afi_ctl_long_idle    <= s.long_idle;
      oct_cal_rdy          <= s.oct_cal_rdy;
      oct_recal_req        <= s.oct_recal_req;
      oct_s2pload_rdy      <= s.oct_s2pload_rdy;
   endtask

   // Latency fields come from one control word, calibration bits from another
   task automatic check_afi_outputs(input seq_ctrl_t lat_src, input seq_ctrl_t cal_src);
      logic [AFI_RLAT_W-1:0] exp_rlat;
      // The DUT has AFI register stages, so read latency is two more, wrapping at 64
      exp_rlat = AFI_RLAT_W'((int'(lat_src.rlat) + 2) % 64);
      check_word("afi_rlat", WB_DATA_W'(afi_rlat), WB_DATA_W'(exp_rlat));
      check_word("afi_wlat", WB_DATA_W'(afi_wlat), WB_DATA_W'(lat_src.wlat));
      check_word("afi_seq_busy", WB_DATA_W'(afi_seq_busy), WB_DATA_W'(lat_src.seq_busy));
      check_bit("oct_cal_req", oct_cal_req, lat_src.oct_cal_req);
      check_bit("oct_s2pload_ena", oct_s2pload_ena, lat_src.oct_s2pload_ena);
      check_bit("afi_cal_success", afi_cal_success, cal_src.cal_success);
      check_bit("afi_cal_fail", afi_cal_fail, cal_src.cal_fail);
      check_bit("afi_cal_in_progress", afi_cal_in_progress, cal_src.cal_in_progress);
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic test_reset_state();
      logic [WB_DATA_W-1:0] rd;
      check_afi_outputs('0, '0);
      check_bit("dcc_stable", dcc_stable, 1'b0);
      wb_read(CSR_CTRL, rd);
      check_word("CTRL", rd, '0);
      wb_read(CSR_STATUS, rd);
      check_word("STATUS", rd, '0);
      wb_read(CSR_EVENT, rd);
      check_word("EVENT", rd, '0);
   endtask

   task automatic test_ctrl_round_trip();
      seq_ctrl_t            w;
      logic [WB_DATA_W-1:0] rd;
      for (int n = 0; n < 8; n++) begin
         w = seq_ctrl_t'(random_bits(WB_DATA_W));
         wb_write(CSR_CTRL, w);
         wb_read(CSR_CTRL, rd);
         check_ctrl("CTRL readback", seq_ctrl_t'(rd), w);
      end
   endtask

   // Every field flips, so each output shows exactly when it moves
   task automatic test_ctrl_timing();
      seq_ctrl_t            prev;
      seq_ctrl_t            cur;
      logic [WB_DATA_W-1:0] rd;
      prev = seq_ctrl_t'(random_bits(WB_DATA_W));
      cur  = seq_ctrl_t'(~prev);
      wb_write(CSR_CTRL, prev);
      repeat (SYNC_LENGTH + 1) @(negedge afi_clk);
      check_afi_outputs(prev, prev);
      wb_issue(1'b1, CSR_CTRL, cur, rd);
      // Ack cycle
      check_bit("dcc_stable", dcc_stable, cur.dcc_stable);
      check_afi_outputs(prev, prev);
      wb_release();
      check_afi_outputs(prev, prev);
      @(negedge afi_clk);
      check_afi_outputs(cur, prev);
      @(negedge afi_clk);
      check_afi_outputs(cur, cur);
   endtask

   task automatic check_status_pattern(input ctl_status_t pat);
      logic [WB_DATA_W-1:0] rd;
      apply_ctl_inputs(pat);
      repeat (REG_AFI + 2) @(negedge afi_clk);
      wb_read(CSR_STATUS, rd);
      check_status("STATUS", ctl_status_t'(rd[$bits(ctl_status_t)-1:0]), pat);
      wb_write(CSR_STATUS, ~rd);
      wb_read(CSR_STATUS, rd);
      check_status("STATUS after write", ctl_status_t'(rd[$bits(ctl_status_t)-1:0]), pat);
   endtask

   task automatic test_ctl_status();
      logic [WB_DATA_W-1:0] rd;
      check_status_pattern(ctl_status_t'(6'b101101));
      check_status_pattern(ctl_status_t'(6'b010010));
      apply_ctl_inputs('0);
      repeat (REG_AFI + 2) @(negedge afi_clk);
      // Both requests were raised by the patterns above and are cleared here
      wb_write(CSR_EVENT, 32'h3);
      wb_read(CSR_EVENT, rd);
      check_word("EVENT cleared", rd, '0);
   endtask

   task automatic test_sticky_events();
      ctl_status_t          pulse;
      logic [WB_DATA_W-1:0] rd;
      logic [WB_DATA_W-1:0] both;
      pulse               = '0;
      pulse.cal_req       = 1'b1;
      pulse.oct_recal_req = 1'b1;
      both                = '0;
      both[EVT_CAL_REQ]   = 1'b1;
      both[EVT_OCT_RCAL]  = 1'b1;
      apply_ctl_inputs(pulse);
      apply_ctl_inputs('0);
      repeat (REG_AFI + 3) @(negedge afi_clk);
      wb_read(CSR_EVENT, rd);
      check_word("EVENT set", rd, both);
      repeat (4) @(negedge afi_clk);
      wb_read(CSR_EVENT, rd);
      check_word("EVENT held", rd, both);
      wb_write(CSR_EVENT, 32'(1) << EVT_CAL_REQ);
      wb_read(CSR_EVENT, rd);
      check_word("EVENT one cleared", rd, 32'(1) << EVT_OCT_RCAL);
      wb_write(CSR_EVENT, 32'(1) << EVT_OCT_RCAL);
      wb_read(CSR_EVENT, rd);
      check_word("EVENT all cleared", rd, '0);
   endtask

   task automatic test_bus_protocol();
      seq_ctrl_t            w;
      logic [WB_DATA_W-1:0] rd;
      // No ack without a strobe
      repeat (3) begin
         @(negedge afi_clk);
         check_bit("wb_ack idle", wb_ack, 1'b0);
      end
      for (int n = 0; n < 4; n++) begin
         w = seq_ctrl_t'(random_bits(WB_DATA_W));
         wb_write(CSR_CTRL, w);
         wb_read(CSR_CTRL, rd);
         check_ctrl("CTRL back to back", seq_ctrl_t'(rd), w);
      end
      @(posedge afi_clk);
      check_word("ack cycles", WB_DATA_W'(ack_cycles), WB_DATA_W'(xfer_count));
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      rst                  = 1'b1;
      wb_cyc               = 1'b0;
      wb_stb               = 1'b0;
      wb_we                = 1'b0;
      wb_adr               = '0;
      wb_wdata             = '0;
      afi_cal_req          = 1'b0;
      afi_ctl_refresh_done = 1'b0;
      afi_ctl_long_idle    = 1'b0;
      oct_cal_rdy          = 1'b0;
      oct_recal_req        = 1'b0;
      oct_s2pload_rdy      = 1'b0;
      repeat (2) @(posedge afi_clk);
      rst <= 1'b0;
      @(negedge afi_clk);

      test_reset_state();
      test_ctrl_round_trip();
      test_ctrl_timing();
      test_ctl_status();
      test_sticky_events();
      test_bus_protocol();

      $display("Checks: %0d, errors: %0d, timeouts: %0d",
               check_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== afi_seq_bridge.f ====
+incdir+sim
design/afi_seq_pkg.sv
design/afi_seq_ctl_if.sv
design/afi_delay_regs.sv
design/afi_seq_csr.sv
design/afi_seq_phy_if.sv
design/afi_seq_top.sv
sim/tb_afi_seq.sv
